//--- framebuffer_scanout.f
+incdir+.
scanout_pkg.sv
scanout_if.sv
video_timing.sv
line_fetcher.sv
line_buffer.sv
pixel_formatter.sv
framebuffer_scanout.sv
tb_clock_gen.sv
tb_framebuffer_scanout.sv

//--- framebuffer_scanout.sv
`default_nettype none

module framebuffer_scanout (
  input  wire logic                      vga_clk,
  input  wire logic                      rst,
  // framebuffer read port
  output logic                           mem_req,
  output scanout_pkg::mem_addr_t         mem_addr,
  input  wire scanout_pkg::pixel_word_t  mem_rdata,
  input  wire logic                      mem_rvalid,
  // video out
  output scanout_pkg::color_t            red,
  output scanout_pkg::color_t            green,
  output scanout_pkg::color_t            blue,
  output logic                           hsync,
  output logic                           vsync,
  output logic                           blank
);

  video_timing_if vt_if ();
  line_wr_if      wr_if ();

  logic                     rd_bank;
  scanout_pkg::buf_index_t  rd_index;
  scanout_pkg::pixel_word_t rd_data;
  logic                     rd_valid;

  ////////////////////////////////////////////////////////////
  // raster and fetch
  ////////////////////////////////////////////////////////////

  video_timing i_video_timing (
    .vga_clk (vga_clk),
    .rst     (rst),
    .vt      (vt_if)
  );

  line_fetcher i_line_fetcher (
    .vga_clk    (vga_clk),
    .rst        (rst),
    .vt         (vt_if),
    .wr         (wr_if),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_rdata  (mem_rdata),
    .mem_rvalid (mem_rvalid)
  );

  ////////////////////////////////////////////////////////////
  // buffer and pixel path
  ////////////////////////////////////////////////////////////

  line_buffer i_line_buffer (
    .vga_clk  (vga_clk),
    .wr       (wr_if),
    .rd_bank  (rd_bank),
    .rd_index (rd_index),
    .rd_data  (rd_data),
    .rd_valid (rd_valid)
  );

  pixel_formatter i_pixel_formatter (
    .vga_clk  (vga_clk),
    .rst      (rst),
    .vt       (vt_if),
    .rd_bank  (rd_bank),
    .rd_index (rd_index),
    .rd_data  (rd_data),
    .rd_valid (rd_valid),
    .red      (red),
    .green    (green),
    .blue     (blue),
    .hsync    (hsync),
    .vsync    (vsync),
    .blank    (blank)
  );

endmodule

`default_nettype wire

//--- line_buffer.sv
`default_nettype none

`include "scanout_defines.svh"

module line_buffer (
  input  wire logic                     vga_clk,
  line_wr_if.sink                       wr,
  input  wire logic                     rd_bank,
  input  wire scanout_pkg::buf_index_t  rd_index,
  output scanout_pkg::pixel_word_t      rd_data,
  output logic                          rd_valid
);

  scanout_pkg::pixel_word_t bank_mem [0:1][0:`FETCH_WORDS-1];
  logic [1:0]               row_valid;

  // write side, fetcher owned
  always_ff @(posedge vga_clk) begin
    if (wr.we) begin
      bank_mem[wr.bank][wr.index] <= wr.data;
    end
  end

  // one flag per bank
  always_ff @(posedge vga_clk) begin
    if (wr.row_clear) begin
      row_valid[wr.bank] <= 1'b0;
    end else if (wr.row_valid_set) begin
      row_valid[wr.bank] <= 1'b1;
    end
  end

  // registered read, flag travels with the data
  always_ff @(posedge vga_clk) begin
    rd_data  <= bank_mem[rd_bank][rd_index];
    rd_valid <= row_valid[rd_bank];
  end

endmodule

`default_nettype wire

//--- line_fetcher.sv
`default_nettype none

`include "scanout_defines.svh"

module line_fetcher (
  input  wire logic                      vga_clk,
  input  wire logic                      rst,
  video_timing_if.sink                   vt,
  line_wr_if.source                      wr,
  output logic                           mem_req,
  output scanout_pkg::mem_addr_t         mem_addr,
  input  wire scanout_pkg::pixel_word_t  mem_rdata,
  input  wire logic                      mem_rvalid
);

  scanout_pkg::fetch_state_t state;
  scanout_pkg::buf_index_t   req_count;
  scanout_pkg::buf_index_t   rsp_count;
  scanout_pkg::mem_addr_t    row_base;
  scanout_pkg::coord_t       next_row;
  logic                      wr_bank;
  logic                      clear_q;
  logic                      rsp_take;
  logic                      last_rsp;

  // row shown on the following line, wrapping at frame end
  always_comb begin
    if (vt.y == scanout_pkg::coord_t'(`V_TOTAL - 1)) begin
      next_row = '0;
    end else begin
      next_row = vt.y + scanout_pkg::coord_t'(1);
    end
  end

  assign rsp_take = mem_rvalid && (state != scanout_pkg::FETCH_IDLE);
  assign last_rsp = rsp_take &&
                    (rsp_count == scanout_pkg::buf_index_t'(`FETCH_WORDS - 1));

  ////////////////////////////////////////////////////////////
  // request and response sequencing
  ////////////////////////////////////////////////////////////

  always_ff @(posedge vga_clk) begin
    if (rst) begin
      state     <= scanout_pkg::FETCH_IDLE;
      req_count <= '0;
      rsp_count <= '0;
      wr_bank   <= 1'b0;
      // bank 0 is cleared through reset, bank 1 on the first line start
      clear_q   <= 1'b1;
      mem_req   <= 1'b0;
    end else begin
      mem_req <= 1'b0;
      clear_q <= 1'b0;
      if (vt.line_start) begin
        // swap banks, the old target is now on screen
        wr_bank   <= ~wr_bank;
        clear_q   <= 1'b1;
        req_count <= '0;
        rsp_count <= '0;
        if (next_row < `FETCH_ROWS) begin
          state <= scanout_pkg::FETCH_RUN;
        end else begin
          state <= scanout_pkg::FETCH_IDLE;
        end
      end else begin
        if (state == scanout_pkg::FETCH_RUN) begin
          mem_req   <= 1'b1;
          req_count <= req_count + scanout_pkg::buf_index_t'(1);
          if (req_count == scanout_pkg::buf_index_t'(`FETCH_WORDS - 1)) begin
            state <= scanout_pkg::FETCH_DRAIN;
          end
        end
        if (rsp_take) begin
          rsp_count <= rsp_count + scanout_pkg::buf_index_t'(1);
          if (last_rsp) begin
            state <= scanout_pkg::FETCH_IDLE;
          end
        end
      end
    end
  end

  // address path
  always_ff @(posedge vga_clk) begin
    if (vt.line_start) begin
      row_base <= scanout_pkg::mem_addr_t'(next_row) << `ROW_SHIFT;
    end
    mem_addr <= row_base | scanout_pkg::mem_addr_t'(req_count);
  end

  // returned words go straight into the target bank
  assign wr.we            = rsp_take;
  assign wr.bank          = wr_bank;
  assign wr.index         = rsp_count;
  assign wr.data          = mem_rdata;
  assign wr.row_valid_set = last_rsp;
  assign wr.row_clear     = clear_q;

endmodule

`default_nettype wire

//--- pixel_formatter.sv
`default_nettype none

`include "scanout_defines.svh"

module pixel_formatter (
  input  wire logic                      vga_clk,
  input  wire logic                      rst,
  video_timing_if.sink                   vt,
  output logic                           rd_bank,
  output scanout_pkg::buf_index_t        rd_index,
  input  wire scanout_pkg::pixel_word_t  rd_data,
  input  wire logic                      rd_valid,
  output scanout_pkg::color_t            red,
  output scanout_pkg::color_t            green,
  output scanout_pkg::color_t            blue,
  output logic                           hsync,
  output logic                           vsync,
  output logic                           blank
);

  logic       disp_bank;
  logic       col_ok;
  logic [4:0] red5;
  logic [5:0] green6;
  logic [4:0] blue5;

  // the toggle lands at column 2, so columns 0 and 1 look ahead
  assign rd_bank  = (vt.x < scanout_pkg::coord_t'(2)) ? ~disp_bank : disp_bank;
  assign rd_index = (vt.x < `FETCH_WORDS) ? scanout_pkg::buf_index_t'(vt.x) : '0;

  // bytes arrive swapped
  assign red5   = rd_data[12:8];
  assign green6 = {rd_data[2:0], rd_data[15:13]};
  assign blue5  = rd_data[7:3];

  ////////////////////////////////////////////////////////////
  // output stage, two cycles behind the counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge vga_clk) begin
    if (rst) begin
      disp_bank <= 1'b1;
      col_ok    <= 1'b0;
      red       <= '0;
      green     <= '0;
      blue      <= '0;
      hsync     <= 1'b0;
      vsync     <= 1'b0;
      blank     <= 1'b1;
    end else begin
      if (vt.line_start) begin
        disp_bank <= ~disp_bank;
      end
      col_ok <= (vt.x < `FETCH_WORDS);
      hsync  <= vt.hsync;
      vsync  <= vt.vsync;
      blank  <= vt.blank;
      if (vt.blank || !col_ok || !rd_valid) begin
        red   <= '0;
        green <= '0;
        blue  <= '0;
      end else begin
        // widen by repeating the top bits
        red   <= {red5, red5[4:2]};
        green <= {green6, green6[5:4]};
        blue  <= {blue5, blue5[4:2]};
      end
    end
  end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# compile and run the scanout testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_framebuffer_scanout \
  -f framebuffer_scanout.f
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_framebuffer_scanout)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

//--- scanout_defines.svh
`ifndef SCANOUT_DEFINES_SVH
`define SCANOUT_DEFINES_SVH

////////////////////////////////////////////////////////////
// raster geometry, 1280x720 at 1648x750 total
////////////////////////////////////////////////////////////

// horizontal, in vga_clk cycles
`define H_ACTIVE      1280
`define H_SYNC_START  1352
`define H_SYNC_END    1360
`define H_TOTAL       1648

// vertical, in lines
`define V_ACTIVE      720
`define V_SYNC_START  723
`define V_SYNC_END    728
`define V_TOTAL       750

////////////////////////////////////////////////////////////
// framebuffer fetch geometry
////////////////////////////////////////////////////////////

// only the top-left 800x600 window has framebuffer data
`define FETCH_WORDS   800
`define FETCH_ROWS    600

// row stride of 1024 words
`define ROW_SHIFT     10
`define MEM_ADDR_W    20

`endif

//--- scanout_if.sv
`default_nettype none

////////////////////////////////////////////////////////////
// raster position and sync, one cycle behind the counters
////////////////////////////////////////////////////////////

interface video_timing_if;
  scanout_pkg::coord_t x;
  scanout_pkg::coord_t y;
  logic                hsync;
  logic                vsync;
  logic                blank;
  logic                line_start;

  modport source (
    output x, y, hsync, vsync, blank, line_start
  );

  modport sink (
    input x, y, hsync, vsync, blank, line_start
  );
endinterface

////////////////////////////////////////////////////////////
// fetcher to line buffer write port
////////////////////////////////////////////////////////////

interface line_wr_if;
  logic                     we;
  logic                     bank;
  scanout_pkg::buf_index_t  index;
  scanout_pkg::pixel_word_t data;
  // flag updates apply to the bank on 'bank'
  logic                     row_valid_set;
  logic                     row_clear;

  modport source (
    output we, bank, index, data, row_valid_set, row_clear
  );

  modport sink (
    input we, bank, index, data, row_valid_set, row_clear
  );
endinterface

`default_nettype wire

//--- scanout_pkg.sv
`default_nettype none

`include "scanout_defines.svh"

package scanout_pkg;

  // raster column or line
  typedef logic [11:0] coord_t;

  // word address into the framebuffer
  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

  // RGB565 with the two bytes swapped
  typedef logic [15:0] pixel_word_t;

  // one output colour channel
  typedef logic [7:0] color_t;

  // word position inside one line buffer bank
  typedef logic [9:0] buf_index_t;

  // line fetcher FSM
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_RUN,
    FETCH_DRAIN
  } fetch_state_t;

endpackage

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 16
) (
  output logic vga_clk,
  output logic rst
);

  initial begin
    vga_clk = 1'b0;
    forever #(PERIOD / 2) vga_clk = ~vga_clk;
  end

  // released on a rising edge after RESET_CYCLES edges
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge vga_clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- tb_framebuffer_scanout.sv
`default_nettype none

`include "scanout_defines.svh"

module tb_framebuffer_scanout;

  localparam int FRAME_CYCLES   = `H_TOTAL * `V_TOTAL;
  // the last test ends late in the third frame after reset
  localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + FRAME_CYCLES / 4;

  logic                     vga_clk;
  logic                     rst;
  logic                     mem_req;
  scanout_pkg::mem_addr_t   mem_addr;
  scanout_pkg::pixel_word_t mem_rdata;
  logic                     mem_rvalid;
  scanout_pkg::color_t      red;
  scanout_pkg::color_t      green;
  scanout_pkg::color_t      blue;
  logic                     hsync;
  logic                     vsync;
  logic                     blank;

  logic [31:0]              lcg_state = 32'h5bb7_52a0;
  scanout_pkg::mem_addr_t   rsp_addr_q[$];
  int                       rsp_due_q[$];
  int                       last_due = 0;
  int                       mem_cycle = 0;
  int                       timeout_count = 0;
  int                       tests_run = 0;
  int                       tests_failed = 0;
  int                       mismatch_count = 0;

  tb_clock_gen #(.PERIOD(100), .RESET_CYCLES(16)) i_clock_gen (
    .vga_clk (vga_clk),
    .rst     (rst)
  );

  framebuffer_scanout i_framebuffer_scanout (.*);

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // framebuffer contents hashed from every address bit
  function automatic scanout_pkg::pixel_word_t word_for(input scanout_pkg::mem_addr_t addr);
    logic [31:0] h;
    h = {12'h000, addr} * 32'h9e37_79b1;
    h = h ^ (h >> 15);
    return h[31:16] ^ h[15:0];
  endfunction

  // byte-swapped RGB565 to 24 bit with the top bits repeated below
  function automatic logic [23:0] expand_rgb565(input scanout_pkg::pixel_word_t w);
    logic [4:0] r5;
    logic [5:0] g6;
    logic [4:0] b5;
    r5 = w[12:8];
    g6 = {w[2:0], w[15:13]};
    b5 = w[7:3];
    return {r5, r5[4:2], g6, g6[5:4], b5, b5[4:2]};
  endfunction

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected, inout int fails);
    if (got !== expected) begin
      fails = fails + 1;
      mismatch_count = mismatch_count + 1;
      $display("mismatch at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, expected);
    end
  endtask

  task automatic report_test(input string name, input int fails);
    tests_run = tests_run + 1;
    if (fails == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %s: failed with %0d mismatches", name, fails);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // memory model with in-order replies after 1 to 8 cycles
  ////////////////////////////////////////////////////////////

  initial begin
    mem_rdata  <= '0;
    mem_rvalid <= 1'b0;
  end

  always @(posedge vga_clk) begin : memory_model
    int due;
    mem_cycle = mem_cycle + 1;
    if (mem_req) begin
      // never before the previous reply
      due = mem_cycle + 1 + int'(lcg_next() >> 29);
      if (due <= last_due) begin
        due = last_due + 1;
      end
      last_due = due;
      rsp_addr_q.push_back(mem_addr);
      rsp_due_q.push_back(due);
    end
    if (rsp_due_q.size() > 0 && rsp_due_q[0] <= mem_cycle) begin
      mem_rvalid <= 1'b1;
      mem_rdata  <= word_for(rsp_addr_q.pop_front());
      void'(rsp_due_q.pop_front());
    end else begin
      mem_rvalid <= 1'b0;
    end
  end

  always @(posedge vga_clk) begin
    timeout_count = timeout_count + 1;
    if (timeout_count >= TIMEOUT_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // directed tests sampling outputs on the falling edge
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    int fails;
    int after;
    fails = 0;
    after = 0;
    @(negedge vga_clk);
    // blank cannot fall before the second cycle after release
    while (after < 2) begin
      compare_value("idle outputs", {4'h0, mem_req, blank, hsync, vsync, red, green, blue},
                    {8'b0000_0100, 24'h0}, fails);
      if (!rst) begin
        after = after + 1;
      end
      @(negedge vga_clk);
    end
    report_test("reset", fails);
  endtask

  task automatic test_line_timing();
    int fails;
    int high;
    int period;
    int active;
    fails = 0;
    while (!hsync) @(negedge vga_clk);
    repeat (3) begin
      high = 0;
      period = 0;
      active = 0;
      // one hsync rise to the next
      while (hsync) begin
        high = high + 1;
        active = active + (blank ? 0 : 1);
        period = period + 1;
        @(negedge vga_clk);
      end
      while (!hsync) begin
        active = active + (blank ? 0 : 1);
        period = period + 1;
        @(negedge vga_clk);
      end
      compare_value("hsync width", high, `H_SYNC_END - `H_SYNC_START, fails);
      compare_value("hsync period", period, `H_TOTAL, fails);
      compare_value("unblanked cycles per line", active, `H_ACTIVE, fails);
    end
    report_test("line timing", fails);
  endtask

  task automatic test_frame_timing();
    int fails;
    int cycles;
    int sync_cycles;
    int active_lines;
    logic prev_blank;
    logic prev_vsync;
    fails = 0;
    cycles = 0;
    sync_cycles = 0;
    active_lines = 0;
    while (!vsync) @(negedge vga_clk);
    prev_blank = blank;
    prev_vsync = 1'b1;
    while (prev_vsync || !vsync) begin
      sync_cycles = sync_cycles + (vsync ? 1 : 0);
      active_lines = active_lines + ((prev_blank && !blank) ? 1 : 0);
      prev_blank = blank;
      prev_vsync = vsync;
      cycles = cycles + 1;
      @(negedge vga_clk);
    end
    compare_value("vsync width", sync_cycles, (`V_SYNC_END - `V_SYNC_START) * `H_TOTAL, fails);
    compare_value("vsync period", cycles, FRAME_CYCLES, fails);
    compare_value("lines with pixels", active_lines, `V_ACTIVE, fails);
    report_test("frame timing", fails);
  endtask

  task automatic test_requests();
    int fails;
    int line;
    int col;
    int row;
    int k;
    int t;
    int last_t;
    fails = 0;
    k = 0;
    t = 0;
    last_t = 0;
    while (!vsync) @(negedge vga_clk);
    // output vsync trails the counters by two cycles
    line = `V_SYNC_START;
    col = 2;
    while (t < FRAME_CYCLES) begin
      if (mem_req) begin
        row = k / `FETCH_WORDS;
        compare_value("request address", 32'(mem_addr),
                      (row << `ROW_SHIFT) + (k % `FETCH_WORDS), fails);
        compare_value("request line", line, (row + `V_TOTAL - 1) % `V_TOTAL, fails);
        if (k % `FETCH_WORDS != 0) begin
          compare_value("request spacing", t - last_t, 1, fails);
        end
        last_t = t;
        k = k + 1;
      end
      t = t + 1;
      col = (col + 1) % `H_TOTAL;
      line = (col == 0) ? (line + 1) % `V_TOTAL : line;
      @(negedge vga_clk);
    end
    compare_value("requests per frame", k, `FETCH_ROWS * `FETCH_WORDS, fails);
    report_test("requests", fails);
  endtask

  // image rows and black regions over one frame counted from vsync
  task automatic test_pixels();
    int fails;
    int row;
    int col;
    logic [23:0] expected;
    fails = 0;
    while (!vsync) @(negedge vga_clk);
    for (row = 0; row < `V_ACTIVE; row++) begin
      while (blank) @(negedge vga_clk);
      col = 0;
      while (!blank) begin
        expected = '0;
        if (row < `FETCH_ROWS && col < `FETCH_WORDS) begin
          expected = expand_rgb565(word_for(scanout_pkg::mem_addr_t'((row << `ROW_SHIFT) + col)));
        end
        compare_value("pixel colour", {8'h0, red, green, blue}, {8'h0, expected}, fails);
        col = col + 1;
        @(negedge vga_clk);
      end
    end
    report_test("pixels", fails);
  endtask

  initial begin
    test_reset();
    test_line_timing();
    fork
      test_frame_timing();
      test_requests();
    join
    test_pixels();
    $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed,
             mismatch_count);
    if (tests_failed == 0 && mismatch_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- video_timing.sv
`default_nettype none

`include "scanout_defines.svh"

module video_timing (
  input  wire logic      vga_clk,
  input  wire logic      rst,
  video_timing_if.source vt
);

  logic last_col;
  logic last_line;

  assign last_col  = (vt.x == scanout_pkg::coord_t'(`H_TOTAL - 1));
  assign last_line = (vt.y == scanout_pkg::coord_t'(`V_TOTAL - 1));

  ////////////////////////////////////////////////////////////
  // column and line counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge vga_clk) begin
    if (rst) begin
      vt.x <= '0;
      vt.y <= '0;
    end else if (last_col) begin
      vt.x <= '0;
      if (last_line) begin
        vt.y <= '0;
      end else begin
        vt.y <= vt.y + scanout_pkg::coord_t'(1);
      end
    end else begin
      vt.x <= vt.x + scanout_pkg::coord_t'(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // sync, blank and line strobe, decoded from the counters
  ////////////////////////////////////////////////////////////

  // all four lag the counter value they come from by one cycle
  always_ff @(posedge vga_clk) begin
    if (rst) begin
      vt.hsync      <= 1'b0;
      vt.vsync      <= 1'b0;
      vt.blank      <= 1'b1;
      vt.line_start <= 1'b0;
    end else begin
      vt.hsync      <= (vt.x >= `H_SYNC_START) && (vt.x < `H_SYNC_END);
      vt.vsync      <= (vt.y >= `V_SYNC_START) && (vt.y < `V_SYNC_END);
      vt.blank      <= (vt.x >= `H_ACTIVE) || (vt.y >= `V_ACTIVE);
      vt.line_start <= (vt.x == '0);
    end
  end

endmodule

`default_nettype wire
